//--- source/knight_nav_consts.svh
// Shared numeric constants for the drive core; include in RTL and testbench sources.
`ifndef KNIGHT_NAV_CONSTS_SVH
`define KNIGHT_NAV_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Heading controller gains.
////////////////////////////////////////////////////////////////////////////

// Proportional gain, applied to the saturated error.
`define P_COEFF 6'h10
// Derivative gain, applied to the saturated error difference.
`define D_COEFF 5'h07

////////////////////////////////////////////////////////////////////////////
// Speed ramp pacing.
////////////////////////////////////////////////////////////////////////////

// Cycles between two ramp ticks.
`define RAMP_DIV 16
// Forward speed change per tick.
`define FRWRD_STEP 32

// Wishbone register map, word addresses.
`define ADR_CTRL    2'd0
`define ADR_TARGET  2'd1
`define ADR_DESIRED 2'd2
`define ADR_STATUS  2'd3

`endif

//--- source/knight_nav_pkg.sv
// Types shared by the drive core blocks and the testbench, referenced by scoped name.
package knight_nav_pkg;

  // Heading, unsigned, wraps modulo 4096.
  typedef logic [11:0] hdg_t;
  // Heading error, signed two's complement.
  typedef logic signed [11:0] err_t;
  // Forward speed, unsigned.
  typedef logic [9:0] frwrd_t;
  // Wheel speed, signed.
  typedef logic signed [10:0] spd_t;

  // Sequencer states.
  typedef enum logic [1:0] {
    NAV_IDLE      = 2'b00,
    NAV_RAMP_UP   = 2'b01,
    NAV_CRUISE    = 2'b10,
    NAV_RAMP_DOWN = 2'b11
  } nav_state_e;

  // Wishbone classic request, host to core.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [15:0] dat_w;
  } wb_req_t;

  // Wishbone classic response, core to host.
  typedef struct packed {
    logic        ack;
    logic [15:0] dat_r;
  } wb_rsp_t;

  // Drive command held in the register block.
  typedef struct packed {
    logic   go;
    frwrd_t target;
    hdg_t   desired;
  } nav_cmd_t;

endpackage

//--- source/nav_regs.sv
// Wishbone classic slave with the drive command registers; instantiated by the core top.
`timescale 1ns/1ns
`include "knight_nav_consts.svh"

module nav_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  knight_nav_pkg::wb_req_t   wb_req,
  output knight_nav_pkg::wb_rsp_t   wb_rsp,
  input  knight_nav_pkg::nav_state_e nav_state,
  input  knight_nav_pkg::frwrd_t    frwrd,
  output knight_nav_pkg::nav_cmd_t  cmd
);

  logic        ack;
  logic [15:0] dat_r;
  logic        req;
  logic [15:0] rd_data;

  // New request that is not yet acknowledged.
  assign req = wb_req.cyc & wb_req.stb & ~ack;

  // Read data mux.
  // STATUS packs the state under the forward speed.
  always_comb begin
    case (wb_req.adr)
      `ADR_CTRL:    rd_data = {15'd0, cmd.go};
      `ADR_TARGET:  rd_data = {6'd0, cmd.target};
      `ADR_DESIRED: rd_data = {4'd0, cmd.desired};
      default:      rd_data = {4'd0, frwrd, nav_state};
    endcase
  end

  // Ack and register writes share the same edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
      cmd <= '0;
    end else begin
      ack <= req;
      if (req && wb_req.we) begin
        case (wb_req.adr)
          `ADR_CTRL:    cmd.go <= wb_req.dat_w[0];
          `ADR_TARGET:  cmd.target <= wb_req.dat_w[9:0];
          `ADR_DESIRED: cmd.desired <= wb_req.dat_w[11:0];
          default:      cmd <= cmd;
        endcase
      end
    end
  end

  // Read data is captured with the ack.
  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_data;
  end

  assign wb_rsp = '{ack: ack, dat_r: dat_r};

  // The host drops its request in the ack cycle.
  a_req_dropped : assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> !(wb_req.cyc && wb_req.stb));

endmodule

//--- source/nav_sequencer.sv
// Drive sequencer FSM with forward-speed ramping; instantiated by the core top.
`timescale 1ns/1ns
`include "knight_nav_consts.svh"

module nav_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  knight_nav_pkg::nav_cmd_t   cmd,
  input  logic                       tick,
  output logic                       ramp_en,
  output logic                       moving,
  output knight_nav_pkg::frwrd_t     frwrd,
  output knight_nav_pkg::nav_state_e nav_state
);

  knight_nav_pkg::nav_state_e nxt_state;
  knight_nav_pkg::frwrd_t     nxt_frwrd;
  knight_nav_pkg::frwrd_t     floor_spd;
  logic [10:0]                step_up;
  logic [10:0]                floor_up;

  // One step up with a spare bit against wrap.
  assign step_up = {1'b0, frwrd} + 11'(`FRWRD_STEP);

  // Ramp-down floor is the target while go holds and zero otherwise.
  assign floor_spd = cmd.go ? cmd.target : '0;
  assign floor_up  = {1'b0, floor_spd} + 11'(`FRWRD_STEP);

  ////////////////////////////////////////////////////////////////////////////
  // Next state and next forward speed.
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state = nav_state;
    nxt_frwrd = frwrd;
    case (nav_state)
      knight_nav_pkg::NAV_IDLE: begin
        if (cmd.go) nxt_state = knight_nav_pkg::NAV_RAMP_UP;
      end
      knight_nav_pkg::NAV_RAMP_UP: begin
        // Stop request or a lowered target turns the ramp around.
        if (!cmd.go || frwrd > cmd.target) begin
          nxt_state = knight_nav_pkg::NAV_RAMP_DOWN;
        end else if (tick) begin
          if (step_up >= {1'b0, cmd.target}) begin
            nxt_frwrd = cmd.target;
            nxt_state = knight_nav_pkg::NAV_CRUISE;
          end else begin
            nxt_frwrd = step_up[9:0];
          end
        end
      end
      knight_nav_pkg::NAV_CRUISE: begin
        if (!cmd.go || frwrd > cmd.target) nxt_state = knight_nav_pkg::NAV_RAMP_DOWN;
        else if (frwrd < cmd.target) nxt_state = knight_nav_pkg::NAV_RAMP_UP;
      end
      default: begin
        // Ramp down toward the floor.
        if (cmd.go && frwrd < cmd.target) begin
          nxt_state = knight_nav_pkg::NAV_RAMP_UP;
        end else if (tick) begin
          if ({1'b0, frwrd} <= floor_up) begin
            nxt_frwrd = floor_spd;
            nxt_state = cmd.go ? knight_nav_pkg::NAV_CRUISE : knight_nav_pkg::NAV_IDLE;
          end else begin
            nxt_frwrd = frwrd - 10'(`FRWRD_STEP);
          end
        end
      end
    endcase
  end

  // State, speed and moving flag all load on the same edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nav_state <= knight_nav_pkg::NAV_IDLE;
      frwrd     <= '0;
      moving    <= 1'b0;
    end else begin
      nav_state <= nxt_state;
      frwrd     <= nxt_frwrd;
      moving    <= (nxt_state != knight_nav_pkg::NAV_IDLE);
    end
  end

  // Timer runs only while ramping.
  assign ramp_en = (nav_state == knight_nav_pkg::NAV_RAMP_UP) ||
                   (nav_state == knight_nav_pkg::NAV_RAMP_DOWN);

  // No overshoot while ramping up against a steady target.
  a_no_overshoot : assert property (@(posedge clk) disable iff (!rst_n)
    (nav_state == knight_nav_pkg::NAV_RAMP_UP) && $stable(cmd.target) |-> frwrd <= cmd.target);

  // A stopped drive holds no forward speed.
  a_stopped_frwrd : assert property (@(posedge clk) disable iff (!rst_n)
    !moving |-> (frwrd == '0));

endmodule

//--- source/ramp_timer.sv
// Ramp pacing timer giving one-cycle ticks while enabled; instantiated by the core top.
`timescale 1ns/1ns
`include "knight_nav_consts.svh"

module ramp_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic ramp_en,
  output logic tick
);

  // Wide enough for the reload value.
  logic [$clog2(`RAMP_DIV)-1:0] cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Down-counter.
  // Zero means unloaded, so the first tick lands RAMP_DIV cycles
  // after enable, then every RAMP_DIV cycles.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (!ramp_en) begin
      // Held cleared while disabled.
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      if (cnt == '0) cnt <= ($clog2(`RAMP_DIV))'(`RAMP_DIV - 1);
      else cnt <= cnt - 1'b1;
      // Terminal count.
      tick <= (cnt == ($clog2(`RAMP_DIV))'(1));
    end
  end

endmodule

//--- source/heading_pid.sv
// Heading PID that turns heading error into left and right wheel speeds; used by the core top.
`timescale 1ns/1ns
`include "knight_nav_consts.svh"

module heading_pid (
  input  logic                   clk,
  input  logic                   rst_n,
  input  knight_nav_pkg::hdg_t   heading,
  input  logic                   heading_vld,
  input  knight_nav_pkg::hdg_t   desired,
  input  logic                   moving,
  input  knight_nav_pkg::frwrd_t frwrd,
  output knight_nav_pkg::spd_t   lft_spd,
  output knight_nav_pkg::spd_t   rght_spd
);

  // Error and its two pipeline stages.
  knight_nav_pkg::err_t error;
  logic signed [9:0]    err_sat_nxt;
  logic signed [9:0]    err_s1, err_s2;
  logic                 vld_s1, vld_s2;
  // Proportional path.
  logic signed [13:0]   p_term;
  // Integral path.
  logic signed [14:0]   err_ext, sum, integrator;
  logic                 ov;
  logic signed [8:0]    i_term;
  // Derivative path.
  logic signed [9:0]    hist1, hist2, prev_err;
  logic signed [10:0]   d_diff;
  logic signed [7:0]    d_diff_sat;
  logic signed [12:0]   d_term;
  // Sum and wheel speeds.
  logic signed [13:0]   pid_term;
  knight_nav_pkg::spd_t frwrd_ext;
  knight_nav_pkg::spd_t raw_lft, raw_rght;

  ////////////////////////////////////////////////////////////////////////////
  // Error and saturation pipeline.
  ////////////////////////////////////////////////////////////////////////////

  // Wraps modulo 4096, so the short way round is taken.
  assign error = desired - heading;

  // Clamp to 10 bits signed.
  assign err_sat_nxt = (!error[11] && |error[10:9]) ? 10'sh1FF :
                       (error[11] && !(&error[10:9])) ? -10'sd512 :
                       error[9:0];

  // Stage one captures a valid sample and stage two follows it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_s1 <= 1'b0;
      vld_s2 <= 1'b0;
      err_s1 <= '0;
      err_s2 <= '0;
    end else begin
      vld_s1 <= heading_vld;
      vld_s2 <= vld_s1;
      if (heading_vld) err_s1 <= err_sat_nxt;
      if (vld_s1) err_s2 <= err_s1;
    end
  end

  // P term.
  assign p_term = err_s2 * $signed(`P_COEFF);

  ////////////////////////////////////////////////////////////////////////////
  // Integrator.
  ////////////////////////////////////////////////////////////////////////////
  assign err_ext = {{5{err_s2[9]}}, err_s2};
  assign sum     = err_ext + integrator;

  // Overflow only when both addends share a sign the sum lacks.
  assign ov = ~(err_ext[14] ^ integrator[14]) & (err_ext[14] ^ sum[14]);

  // Holds on overflow; cleared while stopped.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) integrator <= '0;
    else if (!moving) integrator <= '0;
    else if (vld_s2 && !ov) integrator <= sum;
  end

  assign i_term = integrator[14:6];

  ////////////////////////////////////////////////////////////////////////////
  // Derivative.
  ////////////////////////////////////////////////////////////////////////////

  // History of the last three valid samples.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist1    <= '0;
      hist2    <= '0;
      prev_err <= '0;
    end else if (vld_s2) begin
      hist1    <= err_s2;
      hist2    <= hist1;
      prev_err <= hist2;
    end
  end

  // One spare bit so the difference cannot wrap.
  assign d_diff = {err_s2[9], err_s2} - {prev_err[9], prev_err};

  assign d_diff_sat = (!d_diff[10] && |d_diff[9:7]) ? 8'sh7F :
                      (d_diff[10] && !(&d_diff[9:7])) ? -8'sd128 :
                      d_diff[7:0];

  assign d_term = d_diff_sat * $signed(`D_COEFF);

  ////////////////////////////////////////////////////////////////////////////
  // Sum and wheel speeds.
  ////////////////////////////////////////////////////////////////////////////

  // P is halved before the sum.
  assign pid_term = {p_term[13], p_term[13:1]} + {{5{i_term[8]}}, i_term} +
                    {d_term[12], d_term};

  assign frwrd_ext = {1'b0, frwrd};

  // Zero while stopped.
  assign raw_lft  = moving ? frwrd_ext + pid_term[13:3] : '0;
  assign raw_rght = moving ? frwrd_ext - pid_term[13:3] : '0;

  // A wrap to negative against the correction sign clamps to full speed.
  assign lft_spd  = (!pid_term[13] && raw_lft[10]) ? 11'sh3FF : raw_lft;
  assign rght_spd = (pid_term[13] && raw_rght[10]) ? 11'sh3FF : raw_rght;

  // A positive correction never leaves the left wheel below the forward speed.
  a_lft_not_slow : assert property (@(posedge clk) disable iff (!rst_n)
    moving && !pid_term[13] |-> lft_spd >= frwrd_ext);

endmodule

//--- source/knight_nav.sv
// Top of the heading-hold drive core, connecting registers, sequencer, timer and PID.
`timescale 1ns/1ns

module knight_nav (
  input  logic                    clk,
  input  logic                    rst_n,
  input  knight_nav_pkg::wb_req_t wb_req,
  output knight_nav_pkg::wb_rsp_t wb_rsp,
  input  knight_nav_pkg::hdg_t    heading,
  input  logic                    heading_vld,
  output knight_nav_pkg::spd_t    lft_spd,
  output knight_nav_pkg::spd_t    rght_spd,
  output logic                    moving
);

  // Command from the register block.
  knight_nav_pkg::nav_cmd_t   cmd;
  // Sequencer status.
  knight_nav_pkg::nav_state_e nav_state;
  knight_nav_pkg::frwrd_t     frwrd;
  // Ramp pacing handshake.
  logic                       ramp_en;
  logic                       tick;

  ////////////////////////////////////////////////////////////////////////////
  // Host registers.
  ////////////////////////////////////////////////////////////////////////////
  nav_regs regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .nav_state (nav_state),
    .frwrd     (frwrd),
    .cmd       (cmd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Speed sequencing.
  ////////////////////////////////////////////////////////////////////////////
  nav_sequencer seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .tick      (tick),
    .ramp_en   (ramp_en),
    .moving    (moving),
    .frwrd     (frwrd),
    .nav_state (nav_state)
  );

  ramp_timer timer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ramp_en (ramp_en),
    .tick    (tick)
  );

  // Heading controller.
  heading_pid pid_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .heading     (heading),
    .heading_vld (heading_vld),
    .desired     (cmd.desired),
    .moving      (moving),
    .frwrd       (frwrd),
    .lft_spd     (lft_spd),
    .rght_spd    (rght_spd)
  );

endmodule

//--- test/tb_clock_gen.sv
// Testbench clock and reset source for the drive core simulation.
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 20 ns period.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held low for 10 cycles, released on a falling edge.
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- test/knight_nav_tb.sv
// Testbench for the drive core; replays test/knight_nav_testdata.txt and checks the responses.
`timescale 1ns/1ns
`include "knight_nav_consts.svh"

module knight_nav_tb;

  localparam logic [15:0] LFSR_SEED = 16'd63036;
  // Cycles allowed per Wishbone access or heading sample.
  localparam int WB_MARGIN = 4;
  // Cycles allowed for one full ramp.
  localparam int RAMP_BUDGET = (1024 / `FRWRD_STEP + 2) * `RAMP_DIV;

  logic                    clk;
  logic                    rst_n;
  knight_nav_pkg::wb_req_t wb_req;
  knight_nav_pkg::wb_rsp_t wb_rsp;
  knight_nav_pkg::hdg_t    heading;
  logic                    heading_vld;
  knight_nav_pkg::spd_t    lft_spd;
  knight_nav_pkg::spd_t    rght_spd;
  logic                    moving;

  // Records from the data file.
  string ops[$];
  int    arg_a[$];
  int    arg_b[$];

  int          limit_cycles = 0;
  int          cyc_cnt = 0;
  logic [15:0] lfsr = LFSR_SEED;
  // Model state.
  int          exp_frwrd = 0;
  int          exp_desired = 0;

  tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  knight_nav dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .heading     (heading),
    .heading_vld (heading_vld),
    .lft_spd     (lft_spd),
    .rght_spd    (rght_spd),
    .moving      (moving)
  );

  // Cycle count that times the ramp steps.
  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("ERR %0t %s actual=%0d expected=%0d", $time, name, act, exp);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  // Galois LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and sensor drivers that are called just after a falling edge.
  ////////////////////////////////////////////////////////////////////////////

  // Ack must come one cycle after the request and last one cycle.
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] data,
                           output logic [15:0] rd);
    check_val("wb_ack", int'(wb_rsp.ack), 0);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data};
    @(negedge clk);
    check_val("wb_ack", int'(wb_rsp.ack), 1);
    rd = wb_rsp.dat_r;
    wb_req = '0;
    @(negedge clk);
    check_val("wb_ack", int'(wb_rsp.ack), 0);
  endtask

  // Returns once the sample's P and D terms reach the speeds.
  task automatic heading_sample(input int hdg);
    heading     = 12'(hdg);
    heading_vld = 1'b1;
    @(negedge clk);
    heading_vld = 1'b0;
    @(negedge clk);
  endtask

  // Polls STATUS until frwrd reaches goal at one step per RAMP_DIV cycles.
  task automatic ramp_track(input int goal, input int chk_spd);
    logic [15:0] rd;
    int          prev;
    int          f;
    int          stepped;
    int          last_chg;
    int          l;
    int          r;
    bit          seen;
    prev = exp_frwrd;
    f = prev;
    seen = 0;
    last_chg = 0;
    while (f != goal) begin
      // Speeds here match the frwrd that STATUS captures next edge.
      l = lft_spd;
      r = rght_spd;
      wb_access(1'b0, `ADR_STATUS, 16'd0, rd);
      f = int'(rd[11:2]);
      if (goal > prev) stepped = (prev + `FRWRD_STEP > goal) ? goal : prev + `FRWRD_STEP;
      else stepped = (prev - `FRWRD_STEP < goal) ? goal : prev - `FRWRD_STEP;
      check_val("frwrd_step", ((f == prev) || (f == stepped)) ? 1 : 0, 1);
      if (chk_spd != 0) begin
        check_val("lft_spd", l, f);
        check_val("rght_spd", r, f);
      end
      if (f != prev) begin
        if (seen) check_val("ramp_interval", cyc_cnt - last_chg, `RAMP_DIV);
        seen = 1;
        last_chg = cyc_cnt;
        prev = f;
      end
    end
    exp_frwrd = goal;
  endtask

  // Random headings near DESIRED; the first one has a positive error.
  task automatic random_headings(input int n, input int span);
    int v;
    int e;
    int l;
    int r;
    for (int i = 0; i < n; i++) begin
      take_bits(9, v);
      e = v % (2 * span + 1) - span;
      if (i == 0 && e <= 0) e = 1 - e;
      heading_sample((exp_desired - e) & 'hFFF);
      l = lft_spd;
      r = rght_spd;
      if (l != 'h3FF && r != 'h3FF) check_val("lft_spd+rght_spd", l + r, 2 * exp_frwrd);
      // History and integrator are still zero for the first sample.
      if (i == 0) check_val("lft_gt_rght", (l > r) ? 1 : 0, 1);
    end
  endtask

  // Large positive error drives the left wheel into its clamp.
  task automatic clamp_headings(input int n, input int hdg);
    int l;
    repeat (n) begin
      heading_sample(hdg);
      l = lft_spd;
      check_val("lft_spd_negative", (l < 0) ? 1 : 0, 0);
      check_val("lft_spd", l, 'h3FF);
    end
  endtask

  // Ends the run if the sequence takes longer than its budget.
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    abort_run("Timeout: the test sequence did not finish within its cycle budget.");
  end

  initial begin
    int          fd;
    int          code;
    int          a;
    int          b;
    int          budget;
    string       line;
    string       op;
    logic [15:0] rd;
    wb_req      = '0;
    heading     = '0;
    heading_vld = 1'b0;
    budget      = 40;

    fd = $fopen("test/knight_nav_testdata.txt", "r");
    if (fd == 0) abort_run("Could not open the test data file.");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        a = 0;
        b = 0;
        code = $sscanf(line, "%s %d %d", op, a, b);
        ops.push_back(op);
        arg_a.push_back(a);
        arg_b.push_back(b);
        case (op)
          "N":      budget += a;
          "L", "M": budget += a * WB_MARGIN;
          "U":      budget += RAMP_BUDGET;
          default:  budget += WB_MARGIN;
        endcase
      end
    end
    $fclose(fd);
    limit_cycles = budget;

    wait (rst_n === 1'b1);
    @(negedge clk);

    ////////////////////////////////////////////////////////////////////////////
    // Record replay.
    ////////////////////////////////////////////////////////////////////////////
    foreach (ops[i]) begin
      a = arg_a[i];
      b = arg_b[i];
      case (ops[i])
        "W": begin
          wb_access(1'b1, 2'(a), 16'(b), rd);
          if (a == `ADR_DESIRED) exp_desired = b;
        end
        "R": begin
          wb_access(1'b0, 2'(a), 16'd0, rd);
          check_val("wb_dat_r", int'(rd), b);
        end
        "H": heading_sample(a);
        "N": repeat (a) @(negedge clk);
        "V": check_val("moving", int'(moving), a);
        "E": begin
          check_val("lft_spd", int'(lft_spd), a);
          check_val("rght_spd", int'(rght_spd), b);
        end
        "U": ramp_track(a, b);
        "L": random_headings(a, b);
        "M": clamp_headings(a, b);
        default: abort_run("Unknown operation code in the test data file.");
      endcase
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- knight_nav.f
+incdir+source
source/knight_nav_pkg.sv
source/nav_regs.sv
source/nav_sequencer.sv
source/ramp_timer.sv
source/heading_pid.sv
source/knight_nav.sv
test/tb_clock_gen.sv
test/knight_nav_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the drive core testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f knight_nav.f --top-module knight_nav_tb -o knight_nav_sim

# The simulation may stop with a failure status; the log decides.
./obj_dir/knight_nav_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed."
  exit 0
fi
echo "Simulation failed."
exit 1

//--- test/knight_nav_testdata.txt
# op a b, decimal. W adr data | R adr expected | H heading | N cycles | V moving
# E lft rght | U frwrd_goal check_speeds | L count span | M count heading
V 0
E 0 0
R 3 0
R 0 0
W 1 512
R 1 512
W 2 1000
R 2 1000
H 1000
W 0 1
U 512 1
E 512 512
R 3 2050
L 12 200
W 1 1000
U 1000 0
M 6 600
W 0 0
U 0 0
N 2
V 0
R 3 0
E 0 0
H 1000
H 1000
H 1000
H 1000
W 0 1
U 1000 1
E 1000 1000
R 3 4002
